// File: hw/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// cache geometry
`define ICACHE_WAYS         2
`define ICACHE_SETS         8
`define ICACHE_LINE_WORDS   4

// fetch address width in bits
`define ICACHE_ADDR_W       32

`endif

// File: hw/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    localparam int INDEX_W  = $clog2(`ICACHE_SETS);
    localparam int OFFSET_W = $clog2(`ICACHE_LINE_WORDS);
    localparam int TAG_W    = `ICACHE_ADDR_W - INDEX_W - OFFSET_W - 2;

    typedef logic [TAG_W-1:0]        tag_t;
    typedef logic [INDEX_W-1:0]      index_t;
    typedef logic [OFFSET_W-1:0]     offset_t;
    typedef logic [31:0]             word_t;
    typedef logic [`ICACHE_WAYS-1:0] way_sel_t;

    // field view of a fetch address with the msb first
    typedef struct packed {
        tag_t       tag;
        index_t     index;
        offset_t    offset;
        logic [1:0] byte_off;
    } fetch_fields_t;

    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        fetch_fields_t             fields;
    } fetch_addr_u;

endpackage

// File: hw/axi_pkg.sv
`include "icache_macros.svh"

package axi_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // holds 0 up to a full line of beats
    typedef logic [$clog2(`ICACHE_LINE_WORDS + 1)-1:0] beat_cnt_t;

endpackage

// File: hw/icache_way_if.sv
`timescale 1ns/1ps

interface icache_way_if;

    // lookup side
    icache_pkg::index_t  lookup_index;
    icache_pkg::tag_t    lookup_tag;
    icache_pkg::offset_t lookup_offset;
    logic                hit;
    icache_pkg::word_t   rd_data;
    logic                inval_all;

    // fill side takes one beat per cycle
    logic                fill_en;
    icache_pkg::index_t  fill_index;
    icache_pkg::offset_t fill_offset;
    icache_pkg::tag_t    fill_tag;
    icache_pkg::word_t   fill_data;
    logic                fill_last;

    modport ctrl (
        output lookup_index, lookup_tag, lookup_offset, inval_all,
        input  hit, rd_data
    );

    modport refill (
        output fill_en, fill_index, fill_offset, fill_tag, fill_data, fill_last
    );

    modport way (
        input  lookup_index, lookup_tag, lookup_offset, inval_all,
        input  fill_en, fill_index, fill_offset, fill_tag, fill_data, fill_last,
        output hit, rd_data
    );

endinterface

// File: hw/icache_way.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_way (
    input  logic        clock,
    input  logic        i_rst_n,
    icache_way_if.way   way_if
);

    logic [`ICACHE_SETS-1:0] valid_q;
    icache_pkg::tag_t        tag_mem [`ICACHE_SETS];
    icache_pkg::word_t       data_mem [`ICACHE_SETS][`ICACHE_LINE_WORDS];

    // a line being refilled stays invalid until its last good beat
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            valid_q <= '0;
        end else if (way_if.inval_all) begin
            valid_q <= '0;
        end else if (way_if.fill_en) begin
            valid_q[way_if.fill_index] <= way_if.fill_last;
        end
    end

    always_ff @(posedge clock) begin
        if (way_if.fill_en) begin
            data_mem[way_if.fill_index][way_if.fill_offset] <= way_if.fill_data;
            if (way_if.fill_last) begin
                tag_mem[way_if.fill_index] <= way_if.fill_tag;
            end
        end
    end

    assign way_if.hit     = valid_q[way_if.lookup_index]
                            && (tag_mem[way_if.lookup_index] == way_if.lookup_tag);
    assign way_if.rd_data = data_mem[way_if.lookup_index][way_if.lookup_offset];

    // refill and fence are never active together
    assert property (@(posedge clock) disable iff (!i_rst_n)
        !(way_if.fill_en && way_if.inval_all))
        else $error("icache_way: fill during invalidate");

endmodule

// File: hw/icache_ctrl.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                       clock,
    input  logic                       i_rst_n,
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_req_addr,
    output logic                       o_rsp_valid,
    input  logic                       i_rsp_ready,
    output icache_pkg::word_t          o_rsp_data,
    output logic                       o_rsp_err,
    input  logic                       i_fence_i,
    output logic                       o_miss_valid,
    input  logic                       i_miss_ready,
    output logic [`ICACHE_ADDR_W-1:0]  o_miss_addr,
    output icache_pkg::way_sel_t       o_victim,
    input  logic                       i_refill_done,
    input  logic                       i_refill_err,
    icache_way_if.ctrl                 way_if [`ICACHE_WAYS]
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MISS,
        ST_REFILL,
        ST_RESP
    } state_e;

    state_e                  state_q;
    icache_pkg::fetch_addr_u addr_q;
    icache_pkg::fetch_addr_u lookup_addr;
    icache_pkg::way_sel_t    rr_q [`ICACHE_SETS];
    icache_pkg::way_sel_t    hit_vec;
    icache_pkg::word_t       rd_word [`ICACHE_WAYS];
    icache_pkg::word_t       hit_word;
    icache_pkg::word_t       rsp_data_q;
    logic                    rsp_err_q;
    logic                    req_fire;
    logic                    inval_all;

    // idle looks at the incoming address so a hit answers next cycle
    assign lookup_addr.raw = (state_q == ST_IDLE) ? i_req_addr : addr_q.raw;

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_way
        assign way_if[g].lookup_index  = lookup_addr.fields.index;
        assign way_if[g].lookup_tag    = lookup_addr.fields.tag;
        assign way_if[g].lookup_offset = lookup_addr.fields.offset;
        assign way_if[g].inval_all     = inval_all;
        assign hit_vec[g]              = way_if[g].hit;
        assign rd_word[g]              = way_if[g].rd_data;
    end

    always_comb begin
        hit_word = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (hit_vec[w]) begin
                hit_word = hit_word | rd_word[w];
            end
        end
    end

    assign o_req_ready  = (state_q == ST_IDLE);
    assign req_fire     = i_req_valid && o_req_ready;
    assign inval_all    = o_req_ready && !i_req_valid && i_fence_i;
    assign o_miss_valid = (state_q == ST_MISS);
    assign o_miss_addr  = addr_q.raw;
    assign o_victim     = rr_q[addr_q.fields.index];
    assign o_rsp_valid  = (state_q == ST_RESP);
    assign o_rsp_data   = rsp_data_q;
    assign o_rsp_err    = rsp_err_q;

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (req_fire) begin
                        state_q <= (|hit_vec) ? ST_RESP : ST_MISS;
                    end
                end
                ST_MISS: begin
                    if (i_miss_ready) begin
                        state_q <= ST_REFILL;
                    end
                end
                ST_REFILL: begin
                    if (i_refill_done) begin
                        state_q <= ST_RESP;
                    end
                end
                default: begin
                    if (i_rsp_ready) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // round-robin victim per set rotates when the miss is taken
    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                rr_q[s] <= icache_pkg::way_sel_t'(1);
            end
        end else if (o_miss_valid && i_miss_ready) begin
            rr_q[addr_q.fields.index] <= (o_victim << 1) | (o_victim >> (`ICACHE_WAYS - 1));
        end
    end

    // after a good refill the line hits again on addr_q
    always_ff @(posedge clock) begin
        if (req_fire) begin
            addr_q.raw <= i_req_addr;
        end
        if ((req_fire && (|hit_vec)) || ((state_q == ST_REFILL) && i_refill_done)) begin
            rsp_data_q <= hit_word;
            rsp_err_q  <= (state_q == ST_REFILL) && i_refill_err;
        end
    end

    assert property (@(posedge clock) disable iff (!i_rst_n) $onehot0(hit_vec))
        else $error("icache_ctrl: tag found in more than one way");

    assert property (@(posedge clock) disable iff (!i_rst_n)
        i_refill_done |-> (state_q == ST_REFILL))
        else $error("icache_ctrl: refill done with no miss outstanding");

endmodule

// File: hw/axi_refill.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module axi_refill (
    input  logic                       clock,
    input  logic                       i_rst_n,
    input  logic                       i_miss_valid,
    output logic                       o_miss_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_miss_addr,
    input  icache_pkg::way_sel_t       i_victim,
    output logic [`ICACHE_ADDR_W-1:0]  o_araddr,
    output logic                       o_arvalid,
    input  logic                       i_arready,
    input  icache_pkg::word_t          i_rdata,
    input  logic [1:0]                 i_rresp,
    input  logic                       i_rvalid,
    input  logic                       i_rlast,
    output logic                       o_rready,
    output logic                       o_done,
    output logic                       o_err,
    icache_way_if.refill               way_if [`ICACHE_WAYS]
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA,
        ST_DONE
    } state_e;

    state_e                  state_q;
    icache_pkg::fetch_addr_u miss_line;
    icache_pkg::fetch_addr_u line_q;
    icache_pkg::way_sel_t    victim_q;
    axi_pkg::beat_cnt_t      beat_q;
    logic                    err_q;
    logic                    miss_fire;
    logic                    beat_fire;
    logic                    beat_err;

    // line base with word offset and byte bits cleared
    always_comb begin
        miss_line.raw             = i_miss_addr;
        miss_line.fields.offset   = '0;
        miss_line.fields.byte_off = '0;
    end

    assign o_miss_ready = (state_q == ST_IDLE);
    assign o_arvalid    = (state_q == ST_ADDR);
    assign o_rready     = (state_q == ST_DATA);
    assign o_done       = (state_q == ST_DONE);
    assign o_err        = err_q;
    assign o_araddr     = line_q.raw;
    assign miss_fire    = i_miss_valid && o_miss_ready;
    assign beat_fire    = i_rvalid && o_rready;
    assign beat_err     = !(i_rresp inside {axi_pkg::OKAY, axi_pkg::EXOKAY});

    always_ff @(posedge clock) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
            beat_q  <= '0;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (miss_fire) begin
                        state_q <= ST_ADDR;
                        beat_q  <= '0;
                        err_q   <= 1'b0;
                    end
                end
                ST_ADDR: begin
                    if (i_arready) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (beat_fire) begin
                        beat_q <= beat_q + 1'b1;
                        err_q  <= err_q | beat_err;
                        if (i_rlast) begin
                            state_q <= ST_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (miss_fire) begin
            line_q   <= miss_line;
            victim_q <= i_victim;
        end
    end

    // only the victim way takes the beats
    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_fill
        assign way_if[g].fill_en     = beat_fire && victim_q[g];
        assign way_if[g].fill_index  = line_q.fields.index;
        assign way_if[g].fill_offset = icache_pkg::offset_t'(beat_q);
        assign way_if[g].fill_tag    = line_q.fields.tag;
        assign way_if[g].fill_data   = i_rdata;
        assign way_if[g].fill_last   = i_rlast && !err_q && !beat_err;
    end

    assert property (@(posedge clock) disable iff (!i_rst_n)
        beat_fire |-> (i_rlast == (beat_q == `ICACHE_LINE_WORDS - 1)))
        else $error("axi_refill: rlast not on the last beat of the line");

endmodule

// File: hw/icache_top.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module icache_top (
    input  logic                       clock,
    input  logic                       i_rst_n,
    // fetch request
    input  logic                       i_req_valid,
    output logic                       o_req_ready,
    input  logic [`ICACHE_ADDR_W-1:0]  i_req_addr,
    // fetch response
    output logic                       o_rsp_valid,
    input  logic                       i_rsp_ready,
    output logic [31:0]                o_rsp_data,
    output logic                       o_rsp_err,
    input  logic                       i_fence_i,
    // AXI read address
    output logic [`ICACHE_ADDR_W-1:0]  o_araddr,
    output logic                       o_arvalid,
    input  logic                       i_arready,
    // AXI read data
    input  logic [31:0]                i_rdata,
    input  logic [1:0]                 i_rresp,
    input  logic                       i_rvalid,
    input  logic                       i_rlast,
    output logic                       o_rready
);

    logic                       miss_valid;
    logic                       miss_ready;
    logic [`ICACHE_ADDR_W-1:0]  miss_addr;
    icache_pkg::way_sel_t       victim;
    logic                       refill_done;
    logic                       refill_err;

    icache_way_if way_bus [`ICACHE_WAYS] ();

    icache_ctrl icache_ctrl_i (
        .clock         (clock),
        .i_rst_n       (i_rst_n),
        .i_req_valid   (i_req_valid),
        .o_req_ready   (o_req_ready),
        .i_req_addr    (i_req_addr),
        .o_rsp_valid   (o_rsp_valid),
        .i_rsp_ready   (i_rsp_ready),
        .o_rsp_data    (o_rsp_data),
        .o_rsp_err     (o_rsp_err),
        .i_fence_i     (i_fence_i),
        .o_miss_valid  (miss_valid),
        .i_miss_ready  (miss_ready),
        .o_miss_addr   (miss_addr),
        .o_victim      (victim),
        .i_refill_done (refill_done),
        .i_refill_err  (refill_err),
        .way_if        (way_bus)
    );

    axi_refill axi_refill_i (
        .clock         (clock),
        .i_rst_n       (i_rst_n),
        .i_miss_valid  (miss_valid),
        .o_miss_ready  (miss_ready),
        .i_miss_addr   (miss_addr),
        .i_victim      (victim),
        .o_araddr      (o_araddr),
        .o_arvalid     (o_arvalid),
        .i_arready     (i_arready),
        .i_rdata       (i_rdata),
        .i_rresp       (i_rresp),
        .i_rvalid      (i_rvalid),
        .i_rlast       (i_rlast),
        .o_rready      (o_rready),
        .o_done        (refill_done),
        .o_err         (refill_err),
        .way_if        (way_bus)
    );

    for (genvar g = 0; g < `ICACHE_WAYS; g++) begin : g_ways
        icache_way icache_way_i (
            .clock   (clock),
            .i_rst_n (i_rst_n),
            .way_if  (way_bus[g])
        );
    end

endmodule

// File: verif/axi_mem_model.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module axi_mem_model #(
    parameter logic [31:0] DATA_XOR = 32'h0,
    parameter int          SEED     = 16
) (
    input  logic                          clock,
    input  logic                          i_rst_n,
    input  logic [`ICACHE_ADDR_W-1:0]     i_araddr,
    input  logic                          i_arvalid,
    output logic                          o_arready,
    output logic [31:0]                   o_rdata,
    output logic [1:0]                    o_rresp,
    output logic                          o_rvalid,
    output logic                          o_rlast,
    input  logic                          i_rready,
    input  logic [`ICACHE_LINE_WORDS-1:0] i_err_beats
);

    integer                          seed = SEED;
    logic [`ICACHE_ADDR_W-1:0]       base;
    logic [`ICACHE_LINE_WORDS-1:0]   errs;
    int                              gap;

    initial begin
        o_arready = 1'b0;
        o_rdata   = '0;
        o_rresp   = axi_pkg::OKAY;
        o_rvalid  = 1'b0;
        o_rlast   = 1'b0;
        forever begin
            @(posedge clock);
            if (i_rst_n && i_arvalid) begin
                base = i_araddr;
                errs = i_err_beats;
                #1;
                o_arready = 1'b1;
                @(posedge clock);
                #1;
                o_arready = 1'b0;
                for (int b = 0; b < `ICACHE_LINE_WORDS; b++) begin
                    // idle gap of 0 to 3 cycles before each beat
                    gap = $unsigned($random(seed)) % 4;
                    repeat (gap) begin
                        @(posedge clock);
                        #1;
                    end
                    o_rvalid = 1'b1;
                    o_rdata  = (base + 32'(b * 4)) ^ DATA_XOR;
                    o_rresp  = errs[b] ? axi_pkg::SLVERR : axi_pkg::OKAY;
                    o_rlast  = (b == `ICACHE_LINE_WORDS - 1);
                    do begin
                        @(posedge clock);
                    end while (!i_rready);
                    #1;
                    o_rvalid = 1'b0;
                    o_rlast  = 1'b0;
                end
            end
        end
    end

endmodule

// File: verif/tb_icache.sv
`timescale 1ns/1ps
`include "icache_macros.svh"

module tb_icache;

    localparam logic [31:0] MEM_XOR   = 32'h5A3C_96E1;
    localparam int          SEED      = 16;
    localparam int          N_DIRECT  = 16;
    localparam int          N_RAND    = 40;
    localparam int          N_REQ     = N_DIRECT + N_RAND;
    localparam int          CYCLE_LIMIT = 200 * N_REQ + 500;
    localparam int          IDX_LSB   = 2 + $clog2(`ICACHE_LINE_WORDS);
    localparam int          TAG_LSB   = IDX_LSB + $clog2(`ICACHE_SETS);
    localparam int          LINE_BYTES = `ICACHE_LINE_WORDS * 4;

    typedef struct {
        logic [`ICACHE_ADDR_W-1:0] addr;
        logic [31:0]               data;
        logic                      err;
        logic                      ar;
        int                        acc_cycle;
    } pred_t;

    logic                          clock;
    logic                          i_rst_n;
    logic                          i_req_valid;
    logic                          o_req_ready;
    logic [`ICACHE_ADDR_W-1:0]     i_req_addr;
    logic                          o_rsp_valid;
    logic                          i_rsp_ready;
    logic [31:0]                   o_rsp_data;
    logic                          o_rsp_err;
    logic                          i_fence_i;
    logic [`ICACHE_ADDR_W-1:0]     o_araddr;
    logic                          o_arvalid;
    logic                          i_arready;
    logic [31:0]                   i_rdata;
    logic [1:0]                    i_rresp;
    logic                          i_rvalid;
    logic                          i_rlast;
    logic                          o_rready;
    logic [`ICACHE_LINE_WORDS-1:0] err_beats;

    integer      seed = SEED;
    int          cycle_cnt = 0;
    int          issued = 0;
    int          done_cnt = 0;
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    pred_t       pred_q [$];

    // reference state of the cache
    logic        line_valid [`ICACHE_WAYS][`ICACHE_SETS];
    logic [31:0] line_tag [`ICACHE_WAYS][`ICACHE_SETS];
    int          rr_ptr [`ICACHE_SETS];

    // compare process state
    logic        holding = 1'b0;
    int          ar_seen = 0;
    logic [31:0] held_data;
    logic        held_err;

    icache_top icache_top_i (
        .clock       (clock),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .i_req_addr  (i_req_addr),
        .o_rsp_valid (o_rsp_valid),
        .i_rsp_ready (i_rsp_ready),
        .o_rsp_data  (o_rsp_data),
        .o_rsp_err   (o_rsp_err),
        .i_fence_i   (i_fence_i),
        .o_araddr    (o_araddr),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_rdata     (i_rdata),
        .i_rresp     (i_rresp),
        .i_rvalid    (i_rvalid),
        .i_rlast     (i_rlast),
        .o_rready    (o_rready)
    );

    axi_mem_model #(.DATA_XOR(MEM_XOR), .SEED(SEED)) axi_mem_model_i (
        .clock       (clock),
        .i_rst_n     (i_rst_n),
        .i_araddr    (o_araddr),
        .i_arvalid   (o_arvalid),
        .o_arready   (i_arready),
        .o_rdata     (i_rdata),
        .o_rresp     (i_rresp),
        .o_rvalid    (i_rvalid),
        .o_rlast     (i_rlast),
        .i_rready    (o_rready),
        .i_err_beats (err_beats)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // expected data, error flag and whether a burst goes out
    function automatic void predict(input logic [31:0] addr, input logic fail,
                                    output logic [31:0] data, output logic err,
                                    output logic ar);
        int          set;
        int          victim;
        logic [31:0] tag;
        set  = (addr >> IDX_LSB) % `ICACHE_SETS;
        tag  = addr >> TAG_LSB;
        data = {addr[31:2], 2'b00} ^ MEM_XOR;
        err  = 1'b0;
        ar   = 1'b1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (line_valid[w][set] && line_tag[w][set] == tag) begin
                ar = 1'b0;
            end
        end
        if (ar) begin
            victim               = rr_ptr[set];
            rr_ptr[set]          = (victim + 1) % `ICACHE_WAYS;
            // a failed refill leaves the victim line invalid
            line_valid[victim][set] = !fail;
            line_tag[victim][set]   = tag;
            err                     = fail;
        end
    endfunction

    function automatic void invalidate_model();
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                line_valid[w][s] = 1'b0;
            end
        end
    endfunction

    task automatic wait_idle();
        while (done_cnt != issued) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic fetch(input logic [31:0] addr, input logic [3:0] errs);
        pred_t p;
        wait_idle();
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        err_beats   = errs;
        do begin
            @(posedge clock);
        end while (!o_req_ready);
        p.addr      = addr;
        p.acc_cycle = cycle_cnt;
        predict(addr, |errs, p.data, p.err, p.ar);
        pred_q.push_back(p);
        issued++;
        #1;
        i_req_valid = 1'b0;
    endtask

    task automatic pulse_fence();
        wait_idle();
        i_fence_i = 1'b1;
        @(posedge clock);
        #1;
        i_fence_i = 1'b0;
        invalidate_model();
    endtask

    task automatic check_ar();
        logic [31:0] base;
        if (pred_q.size() == 0 || !pred_q[0].ar) begin
            $display("ERROR at %0t: AR issued although no miss was expected", $time);
            other_cnt++;
        end else begin
            base = pred_q[0].addr & ~(LINE_BYTES - 1);
            if (o_araddr !== base) begin
                $display("MISMATCH at %0t: araddr %h, expected %h", $time, o_araddr, base);
                mismatch_cnt++;
            end
        end
        ar_seen++;
    endtask

    task automatic check_response();
        pred_t p;
        p = pred_q[0];
        if (!holding) begin
            if (o_rsp_err !== p.err) begin
                $display("MISMATCH at %0t: addr %h err %b, expected %b",
                         $time, p.addr, o_rsp_err, p.err);
                mismatch_cnt++;
            end
            if (!p.err && o_rsp_data !== p.data) begin
                $display("MISMATCH at %0t: addr %h data %h, expected %h",
                         $time, p.addr, o_rsp_data, p.data);
                mismatch_cnt++;
            end
            if (ar_seen != (p.ar ? 1 : 0)) begin
                $display("ERROR at %0t: addr %h caused %0d bursts instead of %0d",
                         $time, p.addr, ar_seen, p.ar ? 1 : 0);
                other_cnt++;
            end
            if (!p.ar && cycle_cnt != p.acc_cycle + 1) begin
                $display("ERROR at %0t: hit on %h answered %0d cycles after acceptance",
                         $time, p.addr, cycle_cnt - p.acc_cycle);
                other_cnt++;
            end
            held_data = o_rsp_data;
            held_err  = o_rsp_err;
        end else if (o_rsp_data !== held_data || o_rsp_err !== held_err) begin
            $display("MISMATCH at %0t: response changed while stalled", $time);
            mismatch_cnt++;
        end
        if (o_req_ready) begin
            $display("ERROR at %0t: request ready while a response is pending", $time);
            other_cnt++;
        end
        if (i_rsp_ready) begin
            void'(pred_q.pop_front());
            holding = 1'b0;
            ar_seen = 0;
            done_cnt++;
        end else begin
            holding = 1'b1;
        end
    endtask

    // compare process samples at the rising edge
    initial begin
        forever begin
            @(posedge clock);
            if (i_rst_n) begin
                if (o_arvalid && i_arready) begin
                    check_ar();
                end
                if ((o_arvalid || o_rready) && o_req_ready) begin
                    $display("ERROR at %0t: request ready while a refill is busy", $time);
                    other_cnt++;
                end
                if (o_rsp_valid && pred_q.size() == 0) begin
                    $display("ERROR at %0t: response without an outstanding request", $time);
                    other_cnt++;
                end else if (o_rsp_valid) begin
                    check_response();
                end else if (holding) begin
                    $display("ERROR at %0t: response withdrawn before it was taken", $time);
                    other_cnt++;
                    holding = 1'b0;
                end
            end
        end
    end

    // random back-pressure on the response side
    initial begin
        i_rsp_ready = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            i_rsp_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        wait (cycle_cnt >= CYCLE_LIMIT);
        $display("ERROR: timeout after %0d cycles, %0d of %0d requests answered",
                 cycle_cnt, done_cnt, issued);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        logic [31:0] addr;
        logic [3:0]  errs;
        i_rst_n     = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_fence_i   = 1'b0;
        err_beats   = '0;
        invalidate_model();
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            rr_ptr[s] = 0;
        end
        repeat (4) @(posedge clock);
        #1;
        i_rst_n = 1'b1;
        if (!o_req_ready || o_rsp_valid || o_arvalid || o_rready) begin
            $display("ERROR at %0t: outputs not at their reset values", $time);
            other_cnt++;
        end

        // miss then hits on the same line
        fetch(32'h0000_1004, 4'b0000);
        fetch(32'h0000_1000, 4'b0000);
        fetch(32'h0000_100C, 4'b0000);
        fetch(32'h0000_1006, 4'b0000);

        // three tags in set 2
        fetch(32'h0000_2020, 4'b0000);
        fetch(32'h0000_20A0, 4'b0000);
        fetch(32'h0000_2120, 4'b0000);
        fetch(32'h0000_20A0, 4'b0000);
        fetch(32'h0000_2020, 4'b0000);

        pulse_fence();
        fetch(32'h0000_1008, 4'b0000);
        fetch(32'h0000_2120, 4'b0000);

        // refill errors mid burst and on the last beat
        fetch(32'h0000_3040, 4'b0100);
        fetch(32'h0000_3044, 4'b0000);
        fetch(32'h0000_3048, 4'b0000);
        fetch(32'h0000_3080, 4'b1000);
        fetch(32'h0000_3080, 4'b0000);

        for (int n = 0; n < N_RAND; n++) begin
            addr = $random(seed) & 32'h0000_07FF;
            errs = 4'b0000;
            if (($random(seed) & 7) == 0) begin
                errs[$unsigned($random(seed)) % 4] = 1'b1;
            end
            fetch(addr, errs);
            if (n % 13 == 12) begin
                pulse_fence();
            end
        end

        wait_idle();
        repeat (2) @(posedge clock);
        $display("checked %0d of %0d requests: %0d mismatches, %0d other errors",
                 done_cnt, N_REQ, mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0 && done_cnt == N_REQ) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: all.f
+incdir+hw
hw/icache_pkg.sv
hw/axi_pkg.sv
hw/icache_way_if.sv
hw/icache_way.sv
hw/icache_ctrl.sv
hw/axi_refill.sv
hw/icache_top.sv
verif/axi_mem_model.sv
verif/tb_icache.sv
